// File: hdl/ads1292_controller.sv
`timescale 1ns/1ps

module ads1292_controller (
	input  logic                i_CLK,
	input  logic                i_RSTN,
	// host
	input  ads_pkg::ads_cmd_t   i_cmd,
	input  logic                i_cmd_valid,
	output logic                o_busy,
	output logic                o_init_done,
	output logic [7:0]          o_reg_rdata,
	output ads_pkg::ads_frame_t o_frame,
	output logic                o_frame_valid,
	// ADS1292 pins
	output logic                o_spi_clk,
	output logic                o_spi_mosi,
	input  logic                i_spi_miso,
	input  logic                i_drdy_n,
	output logic                o_ads_resetn,
	output logic                o_ads_start,
	output logic                o_spi_csn
);
	import ads_pkg::*;

	spi_tx_t w_tx;
	spi_rx_t w_rx;
	logic    w_tx_ready;
	logic    w_drdy_n;    // synchronized
	logic    w_drdy_fall;
	logic    w_settled;
	logic    w_arm;
	logic    w_stream_en;
	logic    w_frame_done;

	// =========================================================================
	// control
	// =========================================================================
	ads_sequencer u_seq (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_cmd        (i_cmd),
		.i_cmd_valid  (i_cmd_valid),
		.o_busy       (o_busy),
		.o_init_done  (o_init_done),
		.o_reg_rdata  (o_reg_rdata),
		.o_tx         (w_tx),
		.i_tx_ready   (w_tx_ready),
		.i_rx         (w_rx),
		.i_drdy_n     (w_drdy_n),
		.i_drdy_fall  (w_drdy_fall),
		.i_settled    (w_settled),
		.o_arm        (w_arm),
		.o_stream_en  (w_stream_en),
		.i_frame_done (w_frame_done),
		.o_ads_resetn (o_ads_resetn),
		.o_ads_start  (o_ads_start),
		.o_spi_csn    (o_spi_csn)
	);

	drdy_monitor u_drdy (
		.i_CLK       (i_CLK),
		.i_RSTN      (i_RSTN),
		.i_drdy_n    (i_drdy_n),
		.i_arm       (w_arm),
		.o_drdy_n    (w_drdy_n),
		.o_drdy_fall (w_drdy_fall),
		.o_settled   (w_settled)
	);

	// =========================================================================
	// data path
	// =========================================================================
	spi_byte_master u_spi (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_tx       (w_tx),
		.o_tx_ready (w_tx_ready),
		.o_rx       (w_rx),
		.o_spi_clk  (o_spi_clk),
		.o_spi_mosi (o_spi_mosi),
		.i_spi_miso (i_spi_miso)
	);

	frame_collector u_frame (
		.i_CLK         (i_CLK),
		.i_RSTN        (i_RSTN),
		.i_stream_en   (w_stream_en),
		.i_rx          (w_rx),
		.o_frame       (o_frame),
		.o_frame_valid (o_frame_valid),
		.o_frame_done  (w_frame_done)
	);

endmodule

// File: hdl/ads_pkg.sv
package ads_pkg;

	// =========================================================================
	// host side command types
	// =========================================================================
	typedef enum logic [2:0] {
		OP_NOP    = 3'd0,
		OP_WREG   = 3'd1,
		OP_RREG   = 3'd2,
		OP_RDATAC = 3'd3,
		OP_SDATAC = 3'd4
	} ads_op_e;

	typedef struct packed {
		ads_op_e    op;
		logic [4:0] addr;  // ADS1292 register address
		logic [7:0] wdata; // WREG payload
	} ads_cmd_t;

	// byte link between sequencer and SPI master
	typedef struct packed {
		logic       valid;
		logic [7:0] byte_data;
	} spi_tx_t;

	typedef struct packed {
		logic       valid;     // one cycle, end of byte
		logic [7:0] byte_data;
	} spi_rx_t;

	// one RDATAC sample, MSB byte first on the wire
	typedef struct packed {
		logic [23:0] status;
		logic [23:0] ch1;
		logic [23:0] ch2;
	} ads_frame_t;

	// =========================================================================
	// ADS1292 opcodes
	// =========================================================================
	localparam logic [7:0] CMD_SDATAC = 8'h11;
	localparam logic [7:0] CMD_RDATAC = 8'h10;
	localparam logic [2:0] OPC_RREG   = 3'b001; // 001r_rrrr
	localparam logic [2:0] OPC_WREG   = 3'b010; // 010r_rrrr

	// timing, shortened for simulation
	localparam int CLKS_PER_HALF_BIT = 2;   // sclk = clk / 4
	localparam int POR_WAIT_CYCLES   = 200;
	localparam int RESET_WAIT_CYCLES = 36;  // reset low time and wait after it
	localparam int CS_HOLD_CYCLES    = 16;  // >= 4 tCLK before csn high
	localparam int SETTLE_PULSES     = 3;   // settled data on 4th drdy
	localparam int FRAME_BYTES       = 9;   // 24 status + 2 x 24 data

	// counter widths
	localparam int HALF_CNT_W   = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;
	localparam int WAIT_CNT_W   = $clog2(POR_WAIT_CYCLES); // longest wait
	localparam int SETTLE_CNT_W = $clog2(SETTLE_PULSES + 1);
	localparam int BYTE_CNT_W   = $clog2(FRAME_BYTES + 1);

endpackage

// File: hdl/ads_sequencer.sv
`timescale 1ns/1ps

module ads_sequencer (
	input  logic              i_CLK,
	input  logic              i_RSTN,
	input  ads_pkg::ads_cmd_t i_cmd,
	input  logic              i_cmd_valid,
	output logic              o_busy,
	output logic              o_init_done,
	output logic [7:0]        o_reg_rdata,
	output ads_pkg::spi_tx_t  o_tx,
	input  logic              i_tx_ready,
	input  ads_pkg::spi_rx_t  i_rx,
	input  logic              i_drdy_n,
	input  logic              i_drdy_fall,
	input  logic              i_settled,
	output logic              o_arm,
	output logic              o_stream_en,
	input  logic              i_frame_done,
	output logic              o_ads_resetn,
	output logic              o_ads_start,
	output logic              o_spi_csn
);
	import ads_pkg::*;

	typedef enum logic [3:0] {
		ST_POR_WAIT,
		ST_RESET_PULSE,
		ST_RESET_WAIT,
		ST_INIT_SDATAC,
		ST_IDLE,
		ST_SEND,
		ST_RREG_CAPTURE,
		ST_STREAM_SETTLE,
		ST_STREAM_WAIT_DRDY,
		ST_STREAM_READ,
		ST_STOP_WAIT,
		ST_CS_HOLD
	} seq_state_e;

	seq_state_e            r_state;
	ads_cmd_t              r_cmd;
	logic [WAIT_CNT_W-1:0] r_wait_cnt;
	logic [WAIT_CNT_W-1:0] w_wait_lim;
	logic [BYTE_CNT_W-1:0] r_byte_idx;
	logic [BYTE_CNT_W-1:0] w_last_idx;
	logic                  r_in_flight; // byte handed to spi master
	logic                  r_stop_req;
	logic                  w_waiting;
	logic                  w_wait_done;
	logic                  w_xfer;
	logic                  w_issue;
	logic                  w_byte_done;
	logic                  w_accept;
	logic                  w_streaming;
	logic [7:0]            w_next_byte;

	// byte n of a register or command sequence
	function automatic logic [7:0] cmd_byte(input ads_cmd_t cmd,
		input logic [BYTE_CNT_W-1:0] idx);
		logic [7:0] b;
		b = 8'h00; // count byte / dummy
		case (cmd.op)
			OP_WREG: begin
				if (idx == '0)
					b = {OPC_WREG, cmd.addr};
				else if (idx == BYTE_CNT_W'(2))
					b = cmd.wdata;
			end
			OP_RREG: begin
				if (idx == '0)
					b = {OPC_RREG, cmd.addr};
			end
			OP_RDATAC: b = CMD_RDATAC;
			OP_SDATAC: b = CMD_SDATAC;
			default:   b = 8'h00;
		endcase
		return b;
	endfunction

	// =========================================================================
	// shared wait counter
	// =========================================================================
	assign w_waiting = (r_state == ST_POR_WAIT) || (r_state == ST_RESET_PULSE) ||
		(r_state == ST_RESET_WAIT) || (r_state == ST_CS_HOLD);

	always_comb begin
		case (r_state)
			ST_POR_WAIT:    w_wait_lim = WAIT_CNT_W'(POR_WAIT_CYCLES - 1);
			ST_RESET_PULSE,
			ST_RESET_WAIT:  w_wait_lim = WAIT_CNT_W'(RESET_WAIT_CYCLES - 1);
			default:        w_wait_lim = WAIT_CNT_W'(CS_HOLD_CYCLES - 1);
		endcase
	end

	assign w_wait_done = w_waiting && (r_wait_cnt == w_wait_lim);

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN)
			r_wait_cnt <= '0;
		else if (w_waiting && !w_wait_done)
			r_wait_cnt <= r_wait_cnt + 1'b1;
		else
			r_wait_cnt <= '0; // zero on entry to every wait
	end

	// =========================================================================
	// byte handshake toward spi master
	// =========================================================================
	assign w_streaming = (r_state == ST_STREAM_SETTLE) ||
		(r_state == ST_STREAM_WAIT_DRDY) || (r_state == ST_STREAM_READ);
	assign w_xfer      = (r_state == ST_SEND) || (r_state == ST_RREG_CAPTURE) ||
		(r_state == ST_STREAM_READ);
	assign w_issue     = w_xfer && !r_in_flight && i_tx_ready &&
		((r_state != ST_STREAM_READ) || (r_byte_idx < BYTE_CNT_W'(FRAME_BYTES)));
	assign w_byte_done = r_in_flight && !o_tx.valid && i_tx_ready; // ready back
	assign w_next_byte = (r_state == ST_STREAM_READ) ? 8'h00 : cmd_byte(r_cmd, r_byte_idx);
	assign w_last_idx  = (r_cmd.op == OP_WREG) ? BYTE_CNT_W'(2) :
		(r_cmd.op == OP_RREG) ? BYTE_CNT_W'(1) : '0; // rreg dummy sent in capture
	assign w_accept    = i_cmd_valid && !o_busy;
	assign o_stream_en = (r_state == ST_STREAM_READ);

	// =========================================================================
	// main FSM
	// =========================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state      <= ST_POR_WAIT;
			r_cmd        <= '0;
			r_byte_idx   <= '0;
			r_in_flight  <= 1'b0;
			r_stop_req   <= 1'b0;
			o_tx         <= '0;
			o_busy       <= 1'b0;
			o_init_done  <= 1'b0;
			o_arm        <= 1'b0;
			o_ads_resetn <= 1'b1;
			o_ads_start  <= 1'b0;
			o_spi_csn    <= 1'b1;
		end else begin
			o_tx.valid <= 1'b0; // single cycle valid
			o_arm      <= 1'b0;
			if (w_issue) begin
				o_tx.valid     <= 1'b1;
				o_tx.byte_data <= w_next_byte;
				r_in_flight    <= 1'b1;
			end else if (w_byte_done) begin
				r_in_flight <= 1'b0;
			end

			// only SDATAC gets in while streaming
			if (w_streaming && w_accept && (i_cmd.op == OP_SDATAC)) begin
				r_stop_req <= 1'b1;
				o_busy     <= 1'b1;
			end

			case (r_state)
				ST_POR_WAIT: begin
					o_busy <= 1'b1; // no host commands during init
					if (w_wait_done) begin
						o_ads_resetn <= 1'b0;
						r_state      <= ST_RESET_PULSE;
					end
				end
				ST_RESET_PULSE: begin
					if (w_wait_done) begin
						o_ads_resetn <= 1'b1;
						r_state      <= ST_RESET_WAIT;
					end
				end
				ST_RESET_WAIT: begin
					if (w_wait_done)
						r_state <= ST_INIT_SDATAC;
				end
				ST_INIT_SDATAC: begin
					r_cmd.op   <= OP_SDATAC; // chip wakes up in RDATAC
					r_byte_idx <= '0;
					o_spi_csn  <= 1'b0;
					r_state    <= ST_SEND;
				end
				ST_IDLE: begin
					if (w_accept) begin
						case (i_cmd.op)
							OP_WREG, OP_RREG, OP_SDATAC, OP_RDATAC: begin
								r_cmd      <= i_cmd;
								r_byte_idx <= '0;
								o_busy     <= 1'b1;
								o_spi_csn  <= 1'b0;
								r_state    <= ST_SEND;
								if (i_cmd.op == OP_RDATAC)
									o_ads_start <= 1'b1; // conversions by pin
							end
							default: r_state <= ST_IDLE;
						endcase
					end
				end
				ST_SEND: begin
					if (w_byte_done) begin
						if (r_byte_idx == w_last_idx) begin
							case (r_cmd.op)
								OP_RDATAC: begin
									o_busy  <= 1'b0; // streaming, csn stays low
									o_arm   <= 1'b1;
									r_state <= ST_STREAM_SETTLE;
								end
								OP_RREG: begin
									r_byte_idx <= r_byte_idx + 1'b1;
									r_state    <= ST_RREG_CAPTURE;
								end
								default: r_state <= ST_CS_HOLD;
							endcase
						end else begin
							r_byte_idx <= r_byte_idx + 1'b1;
						end
					end
				end
				ST_RREG_CAPTURE: begin
					if (w_byte_done)
						r_state <= ST_CS_HOLD;
				end
				ST_STREAM_SETTLE: begin
					if (r_stop_req)
						r_state <= ST_STOP_WAIT;
					else if (i_settled && !o_arm) // count clears on arm
						r_state <= ST_STREAM_WAIT_DRDY;
				end
				ST_STREAM_WAIT_DRDY: begin
					if (r_stop_req) begin
						r_state <= ST_STOP_WAIT;
					end else if (i_drdy_fall) begin
						r_byte_idx <= '0;
						r_state    <= ST_STREAM_READ;
					end
				end
				ST_STREAM_READ: begin
					if (w_byte_done)
						r_byte_idx <= r_byte_idx + 1'b1;
					if (i_frame_done)
						r_state <= r_stop_req ? ST_STOP_WAIT : ST_STREAM_WAIT_DRDY;
				end
				ST_STOP_WAIT: begin
					if (i_drdy_n) begin // keep clear of the drdy pulse
						r_cmd.op   <= OP_SDATAC;
						r_stop_req <= 1'b0;
						r_byte_idx <= '0;
						r_state    <= ST_SEND;
					end
				end
				ST_CS_HOLD: begin
					if (w_wait_done) begin
						o_spi_csn   <= 1'b1;
						o_busy      <= 1'b0;
						o_init_done <= 1'b1; // first pass ends init
						if (r_cmd.op == OP_SDATAC)
							o_ads_start <= 1'b0;
						r_state <= ST_IDLE;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// register read result
	always_ff @(posedge i_CLK) begin
		if ((r_state == ST_RREG_CAPTURE) && i_rx.valid)
			o_reg_rdata <= i_rx.byte_data;
	end

	// bytes only shift with the chip selected
	a_csn_low_while_shifting: assert property (
		@(posedge i_CLK) disable iff (!i_RSTN) !i_tx_ready |-> !o_spi_csn
	) else $error("ads_sequencer: spi byte in progress with csn high");

endmodule

// File: hdl/drdy_monitor.sv
`timescale 1ns/1ps

module drdy_monitor (
	input  logic i_CLK,
	input  logic i_RSTN,
	input  logic i_drdy_n,    // async pin from the ADS1292
	input  logic i_arm,       // restart settle count
	output logic o_drdy_n,
	output logic o_drdy_fall,
	output logic o_settled
);
	import ads_pkg::*;

	logic [1:0]              r_sync;
	logic                    r_last;
	logic [SETTLE_CNT_W-1:0] r_cnt;

	assign o_drdy_n    = r_sync[1];
	assign o_drdy_fall = r_last & ~r_sync[1];                    // 3rd cycle after pin
	assign o_settled   = (r_cnt == SETTLE_CNT_W'(SETTLE_PULSES));

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_sync <= 2'b11; // drdy idles high
			r_last <= 1'b1;
			r_cnt  <= '0;
		end else begin
			r_sync <= {r_sync[0], i_drdy_n};
			r_last <= r_sync[1];
			if (i_arm)
				r_cnt <= '0;
			else if (o_drdy_fall && !o_settled)
				r_cnt <= r_cnt + 1'b1; // saturates at SETTLE_PULSES
		end
	end

endmodule

// File: hdl/frame_collector.sv
`timescale 1ns/1ps

module frame_collector (
	input  logic                i_CLK,
	input  logic                i_RSTN,
	input  logic                i_stream_en,
	input  ads_pkg::spi_rx_t    i_rx,
	output ads_pkg::ads_frame_t o_frame,
	output logic                o_frame_valid,
	output logic                o_frame_done
);
	import ads_pkg::*;

	logic [BYTE_CNT_W-1:0] r_cnt;
	logic [63:0]           r_shift; // first eight bytes of the frame
	logic                  w_take;
	logic                  w_last;

	assign w_take       = i_stream_en && i_rx.valid;
	assign w_last       = (r_cnt == BYTE_CNT_W'(FRAME_BYTES - 1));
	assign o_frame_done = o_frame_valid; // sequencer ends its read burst on this

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_cnt         <= '0;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= w_take && w_last;
			if (!i_stream_en)
				r_cnt <= '0; // drop partial frame
			else if (i_rx.valid)
				r_cnt <= w_last ? '0 : r_cnt + 1'b1;
		end
	end

	// msb byte first
	always_ff @(posedge i_CLK) begin
		if (w_take)
			r_shift <= {r_shift[55:0], i_rx.byte_data};
		if (w_take && w_last)
			o_frame <= {r_shift, i_rx.byte_data}; // held until next frame
	end

endmodule

// File: hdl/spi_byte_master.sv
`timescale 1ns/1ps

module spi_byte_master (
	input  logic             i_CLK,
	input  logic             i_RSTN,
	input  ads_pkg::spi_tx_t i_tx,
	output logic             o_tx_ready,
	output ads_pkg::spi_rx_t o_rx,
	output logic             o_spi_clk,  // mode 1, idles low
	output logic             o_spi_mosi,
	input  logic             i_spi_miso
);
	import ads_pkg::*;

	logic                  r_busy;
	logic [HALF_CNT_W-1:0] r_half_cnt;
	logic [4:0]            r_edge_cnt; // 16 sclk edges per byte
	logic [7:0]            r_tx_sh;
	logic [7:0]            r_rx_sh;
	logic                  r_rx_valid;
	logic                  w_edge;

	// sclk toggles at end of each half bit
	assign w_edge = r_busy && (r_half_cnt == HALF_CNT_W'(CLKS_PER_HALF_BIT - 1));

	assign o_tx_ready     = !r_busy;
	assign o_rx.valid     = r_rx_valid;
	assign o_rx.byte_data = r_rx_sh;

	// =========================================================================
	// clock generation and bit count
	// =========================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_busy     <= 1'b0;
			r_half_cnt <= '0;
			r_edge_cnt <= '0;
			o_spi_clk  <= 1'b0;
			o_spi_mosi <= 1'b0;
			r_rx_valid <= 1'b0;
		end else begin
			r_rx_valid <= 1'b0;
			if (!r_busy) begin
				r_half_cnt <= '0;
				if (i_tx.valid) begin
					r_busy     <= 1'b1;
					r_edge_cnt <= 5'd16;
				end
			end else if (w_edge) begin
				r_half_cnt <= '0;
				o_spi_clk  <= ~o_spi_clk;
				r_edge_cnt <= r_edge_cnt - 5'd1;
				if (!o_spi_clk) begin
					o_spi_mosi <= r_tx_sh[7]; // leading edge drives
				end else if (r_edge_cnt == 5'd1) begin
					r_busy     <= 1'b0; // last trailing edge
					r_rx_valid <= 1'b1;
				end
			end else begin
				r_half_cnt <= r_half_cnt + 1'b1;
			end
		end
	end

	// shift registers
	always_ff @(posedge i_CLK) begin
		if (!r_busy && i_tx.valid)
			r_tx_sh <= i_tx.byte_data;
		else if (w_edge && !o_spi_clk)
			r_tx_sh <= {r_tx_sh[6:0], 1'b0};
		if (w_edge && o_spi_clk)
			r_rx_sh <= {r_rx_sh[6:0], i_spi_miso}; // trailing edge samples
	end

	// sequencer must wait for ready before the next byte
	a_tx_valid_needs_ready: assert property (
		@(posedge i_CLK) disable iff (!i_RSTN) i_tx.valid |-> o_tx_ready
	) else $error("spi_byte_master: tx valid while a byte is shifting");

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_ads1292 -o tb_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// File: sources.f
hdl/ads_pkg.sv
hdl/spi_byte_master.sv
hdl/drdy_monitor.sv
hdl/frame_collector.sv
hdl/ads_sequencer.sv
hdl/ads1292_controller.sv
tests/ads1292_model.sv
tests/tb_ads1292.sv

// File: tests/ads1292_model.sv
`timescale 1ns/1ps

module ads1292_model (
	input  logic        i_CLK,       // model runs off the host clock
	input  logic        i_por_n,     // power-on state of the chip
	input  logic        i_spi_clk,
	input  logic        i_spi_mosi,
	input  logic        i_spi_csn,
	input  logic        i_resetn,
	input  logic        i_start,
	output logic        o_spi_miso,
	output logic        o_drdy_n,
	input  logic [71:0] i_frames [0:15]
);
	import ads_pkg::*;

	localparam int DRDY_PERIOD = 600; // clocks between conversions
	localparam int DRDY_LOW    = 8;

	logic [7:0]  regs [0:31];
	logic        r_sclk_q;
	logic        r_rstn_q;
	logic [7:0]  r_rx_sh;
	logic [7:0]  w_rx_byte;
	logic [7:0]  r_op;          // first byte of the transaction
	logic [71:0] r_out_sh;      // miso bits msb first
	logic [3:0]  r_frame_idx;
	logic        streaming;
	logic        got_first;
	logic [7:0]  first_byte;
	int          rx_bits;
	int          byte_idx;
	int          drdy_timer;
	int          drdy_count;    // pulses since start rose
	int          resetn_lows;
	int          sdatac_count;

	assign w_rx_byte = {r_rx_sh[6:0], i_spi_mosi};

	// =========================================================================
	// spi slave, register file and drdy source
	// =========================================================================
	always @(posedge i_CLK or negedge i_por_n) begin
		if (!i_por_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 8'(i) ^ 8'hA5; // distinct per address
			r_sclk_q     <= 1'b0;
			r_rstn_q     <= 1'b1;
			r_rx_sh      <= 8'h00;
			r_op         <= 8'h00;
			r_out_sh     <= '0;
			r_frame_idx  <= 4'd0;
			streaming    <= 1'b0;
			got_first    <= 1'b0;
			first_byte   <= 8'h00;
			rx_bits      <= 0;
			byte_idx     <= 0;
			drdy_timer   <= 0;
			drdy_count   <= 0;
			resetn_lows  <= 0;
			sdatac_count <= 0;
			o_spi_miso   <= 1'b0;
			o_drdy_n     <= 1'b1;
		end else begin
			r_sclk_q <= i_spi_clk;
			r_rstn_q <= i_resetn;
			if (r_rstn_q && !i_resetn)
				resetn_lows <= resetn_lows + 1; // reset pulses seen

			if (i_spi_csn) begin
				rx_bits  <= 0;
				byte_idx <= 0;
			end else begin
				if (!r_sclk_q && i_spi_clk) begin // mode 1 drives on sclk rise
					o_spi_miso <= r_out_sh[71];
					r_out_sh   <= {r_out_sh[70:0], 1'b0};
				end
				if (r_sclk_q && !i_spi_clk) begin // mosi sampled on sclk fall
					r_rx_sh <= w_rx_byte;
					if (rx_bits == 7) begin
						rx_bits  <= 0;
						byte_idx <= byte_idx + 1;
						if (!got_first) begin
							got_first  <= 1'b1;
							first_byte <= w_rx_byte;
						end
						if (streaming) begin
							if (w_rx_byte == CMD_SDATAC) begin // dummies are 00
								streaming    <= 1'b0;
								sdatac_count <= sdatac_count + 1;
							end
						end else if (byte_idx == 0) begin
							r_op <= w_rx_byte;
							if (w_rx_byte == CMD_SDATAC)
								sdatac_count <= sdatac_count + 1;
							else if (w_rx_byte == CMD_RDATAC)
								streaming <= 1'b1;
						end else if (byte_idx == 1 && r_op[7:5] == OPC_RREG) begin
							r_out_sh <= {regs[r_op[4:0]], 64'h0}; // out on 3rd byte
						end else if (byte_idx == 2 && r_op[7:5] == OPC_WREG) begin
							regs[r_op[4:0]] <= w_rx_byte;
						end
					end else begin
						rx_bits <= rx_bits + 1;
					end
				end
			end

			// conversions run while start is high
			if (!i_start) begin
				drdy_timer <= 0;
				drdy_count <= 0;
				o_drdy_n   <= 1'b1;
			end else if (drdy_timer == DRDY_PERIOD - 1) begin
				drdy_timer <= 0;
				o_drdy_n   <= 1'b0;
				drdy_count <= drdy_count + 1;
				if (streaming && drdy_count >= SETTLE_PULSES) begin
					r_out_sh    <= i_frames[r_frame_idx]; // settled data only
					r_frame_idx <= r_frame_idx + 4'd1;
				end
			end else begin
				drdy_timer <= drdy_timer + 1;
				if (drdy_timer == DRDY_LOW - 1)
					o_drdy_n <= 1'b1;
			end
		end
	end

endmodule

// File: tests/ads1292_testdata.txt
# columns: kind addr_or_index value (hex)
# W write reg, R read reg with expected value, F frame word status|ch1|ch2
W 01 02
W 02 A0
W 04 60
W 05 00
R 01 02
R 02 A0
W 02 E3
R 02 E3
R 04 60
R 05 00
W 0A 0F
R 0A 0F
F 0 C00000123456FEDCBA
F 1 C0000013579B2468AC
F 2 C00000000100FFFFFF
F 3 C000007FFFFF800000

// File: tests/tb_ads1292.sv
`timescale 1ns/1ps

module tb_ads1292;
	import ads_pkg::*;

	localparam int MAX_OPS     = 64;
	localparam int DRDY_PERIOD = 600; // matches the model

	logic        i_CLK;
	logic        i_RSTN;
	ads_cmd_t    cmd;
	logic        cmd_valid;
	logic        busy;
	logic        init_done;
	logic [7:0]  reg_rdata;
	ads_frame_t  frame;
	logic        frame_valid;
	logic        spi_clk;
	logic        spi_mosi;
	logic        spi_miso;
	logic        drdy_n;
	logic        ads_resetn;
	logic        ads_start;
	logic        spi_csn;

	logic [71:0] frame_words [0:15];
	byte         op_kind [0:MAX_OPS-1];
	logic [4:0]  op_addr [0:MAX_OPS-1];
	logic [7:0]  op_val  [0:MAX_OPS-1];
	int          n_ops;
	int          n_frames;
	int          errors;
	logic        loaded;

	ads1292_controller uut (
		.i_CLK         (i_CLK),
		.i_RSTN        (i_RSTN),
		.i_cmd         (cmd),
		.i_cmd_valid   (cmd_valid),
		.o_busy        (busy),
		.o_init_done   (init_done),
		.o_reg_rdata   (reg_rdata),
		.o_frame       (frame),
		.o_frame_valid (frame_valid),
		.o_spi_clk     (spi_clk),
		.o_spi_mosi    (spi_mosi),
		.i_spi_miso    (spi_miso),
		.i_drdy_n      (drdy_n),
		.o_ads_resetn  (ads_resetn),
		.o_ads_start   (ads_start),
		.o_spi_csn     (spi_csn)
	);

	ads1292_model u_model (
		.i_CLK      (i_CLK),
		.i_por_n    (i_RSTN),
		.i_spi_clk  (spi_clk),
		.i_spi_mosi (spi_mosi),
		.i_spi_csn  (spi_csn),
		.i_resetn   (ads_resetn),
		.i_start    (ads_start),
		.o_spi_miso (spi_miso),
		.o_drdy_n   (drdy_n),
		.i_frames   (frame_words)
	);

	initial begin
		i_CLK = 1'b0;
		forever #5 i_CLK = ~i_CLK; // 100 MHz
	end

	// =========================================================================
	// helpers
	// =========================================================================
	task automatic log_mismatch(input string msg);
		$display("FAIL t=%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic load_testdata();
		int          fd;
		int          n;
		string       line;
		byte         kind;
		logic [71:0] idx;
		logic [71:0] val;
		for (int i = 0; i < 16; i++)
			frame_words[i] = {18{4'(i)}};
		fd = $fopen("tests/ads1292_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/ads1292_testdata.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h", kind, idx, val);
					if (n == 3 && kind == "F") begin
						frame_words[idx[3:0]] = val;
						n_frames++;
					end else if (n == 3 && n_ops < MAX_OPS) begin // W or R
						op_kind[n_ops] = kind;
						op_addr[n_ops] = idx[4:0];
						op_val[n_ops]  = val[7:0];
						n_ops++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// one-cycle valid offered only while busy is low
	task automatic send_cmd(input ads_op_e op, input logic [4:0] addr, input logic [7:0] data);
		@(negedge i_CLK);
		while (busy)
			@(negedge i_CLK);
		@(posedge i_CLK);
		#1;
		cmd.op    = op;
		cmd.addr  = addr;
		cmd.wdata = data;
		cmd_valid = 1'b1;
		@(posedge i_CLK);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge i_CLK);
		while (busy)
			@(negedge i_CLK);
	endtask

	task automatic idle_gap();
		repeat ($urandom_range(1, 20)) @(posedge i_CLK);
	endtask

	// =========================================================================
	// stimulus and checks
	// =========================================================================
	initial begin
		int seed;
		int sdatac_before;
		int stray;
		seed      = $urandom(32'h5f6d4475);
		errors    = 0;
		n_ops     = 0;
		n_frames  = 0;
		loaded    = 1'b0;
		cmd       = '0;
		cmd_valid = 1'b0;
		i_RSTN    = 1'b0;
		load_testdata();
		loaded = 1'b1;
		repeat (8) @(posedge i_CLK);
		#1;
		i_RSTN = 1'b1;

		// power-up
		@(negedge i_CLK);
		while (!init_done)
			@(negedge i_CLK);
		if (busy)
			log_mismatch("busy still high after init");
		if (u_model.first_byte != CMD_SDATAC)
			log_mismatch($sformatf("first byte %02h, expected 11", u_model.first_byte));
		if (u_model.resetn_lows != 1)
			log_mismatch($sformatf("resetn pulsed %0d times", u_model.resetn_lows));

		// register traffic in file order
		for (int i = 0; i < n_ops; i++) begin
			if (op_kind[i] == "W") begin
				send_cmd(OP_WREG, op_addr[i], op_val[i]);
				wait_idle();
				if (u_model.regs[op_addr[i]] != op_val[i])
					log_mismatch($sformatf("reg %02h holds %02h, wrote %02h", op_addr[i],
						u_model.regs[op_addr[i]], op_val[i]));
			end else begin
				send_cmd(OP_RREG, op_addr[i], 8'h00);
				wait_idle();
				if (reg_rdata != op_val[i])
					log_mismatch($sformatf("read reg %02h got %02h, expected %02h",
						op_addr[i], reg_rdata, op_val[i]));
			end
			idle_gap();
		end

		// continuous mode
		send_cmd(OP_RDATAC, 5'd0, 8'h00);
		wait_idle();
		for (int k = 0; k < n_frames; k++) begin
			@(negedge i_CLK);
			while (!frame_valid)
				@(negedge i_CLK);
			if (k == 0 && u_model.drdy_count <= SETTLE_PULSES)
				log_mismatch("frame delivered from a settling pulse");
			if (frame != frame_words[k])
				log_mismatch($sformatf("frame %0d is %018h, expected %018h", k, frame,
					frame_words[k]));
			if (!ads_start)
				log_mismatch("start low while streaming");
		end

		// stop
		sdatac_before = u_model.sdatac_count;
		send_cmd(OP_SDATAC, 5'd0, 8'h00);
		wait_idle();
		if (ads_start)
			log_mismatch("start still high after SDATAC");
		if (u_model.sdatac_count != sdatac_before + 1)
			log_mismatch("model did not receive SDATAC");
		stray = 0;
		repeat (5 * DRDY_PERIOD) begin
			@(negedge i_CLK);
			if (frame_valid)
				stray++;
		end
		if (stray != 0)
			log_mismatch($sformatf("%0d frames after stop", stray));

		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog sized from the test length
	initial begin
		int limit;
		wait (loaded);
		limit = POR_WAIT_CYCLES + (n_ops + n_frames + 2) * 2000;
		repeat (limit) @(posedge i_CLK);
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("Something failed");
		$finish;
	end

endmodule
